// File: design/aes_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing constants for the AES-128 core and its word-wide ports
// The datapath is written for AES-128 only
// A block must be a whole number of bus words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// Width of one rx or tx bus word
`define AES_WORD_W 32

// Width of a cipher block and of the key
`define AES_BLOCK_W 128

// Words needed to fill one block
`define AES_WORDS_PER_BLOCK 4

// AES-128 round count where the last one skips MixColumns
`define AES_ROUNDS 10

`endif

// File: design/aes_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and byte-level helpers for the AES-128 core
// Blocks are big-endian by byte, byte 0 in the top 8 bits
// The S-box is the forward table only, no inverse is provided
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "aes_macros.svh"

package aes_pkg;

	typedef logic [`AES_WORD_W-1:0] aes_word_t; // One rx or tx word
	typedef logic [`AES_BLOCK_W-1:0] aes_block_t; // Block or key, byte 0 is the MSB
	typedef logic [3:0] aes_round_cnt_t; // Enough for rounds 0 to 11

	// Forward substitution table
	// Entry 0 sits leftmost so sbox[b] reads naturally
	localparam logic [0:255][7:0] sbox = {
		128'h637c777b_f26b6fc5_3001672b_fed7ab76, // 0x
		128'hca82c97d_fa5947f0_add4a2af_9ca472c0, // 1x
		128'hb7fd9326_363ff7cc_34a5e5f1_71d83115, // 2x
		128'h04c723c3_1896059a_071280e2_eb27b275, // 3x
		128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84, // 4x
		128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf, // 5x
		128'hd0efaafb_434d3385_45f9027f_503c9fa8, // 6x
		128'h51a3408f_929d38f5_bcb6da21_10fff3d2, // 7x
		128'hcd0c13ec_5f974417_c4a77e3d_645d1973, // 8x
		128'h60814fdc_222a9088_46eeb814_de5e0bdb, // 9x
		128'he0323a0a_4906245c_c2d3ac62_9195e479, // Ax
		128'he7c8376d_8dd54ea9_6c56f4ea_657aae08, // Bx
		128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a, // Cx
		128'h703eb566_4803f60e_613557b9_86c11d9e, // Dx
		128'he1f89811_69d98e94_9b1e87e9_ce5528df, // Ex
		128'h8ca1890d_bfe64268_41992d0f_b054bb16  // Fx
	};

	// Multiply by x modulo x^8+x^4+x^3+x+1 (xtime)
	function automatic logic [7:0] gf_double(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00); // Fold back the carry
	endfunction

endpackage

// File: design/rx_word_packer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive side, packs four bus words into one block
// First word written lands in the most significant word
// Writes while full are dropped; only rx_clear empties it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "aes_macros.svh"

module rx_word_packer (
	input  logic               tb_clk,
	input  logic               arst_n,
	input  logic               rx_write,
	input  aes_pkg::aes_word_t rx_data,
	input  logic               rx_clear,
	output aes_pkg::aes_block_t block_in,
	output logic               rx_full
);

	localparam int cnt_w = $clog2(`AES_WORDS_PER_BLOCK) + 1; // Counts 0 to 4 inclusive
	localparam logic [cnt_w-1:0] cnt_full = cnt_w'(`AES_WORDS_PER_BLOCK);

	logic [cnt_w-1:0] cnt_q; // Words held so far
	aes_pkg::aes_block_t block_q;
	logic wr_ok;

	assign wr_ok = rx_write && !rx_full; // Overflow writes fall on the floor
	assign rx_full = (cnt_q == cnt_full);
	assign block_in = block_q;

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
			cnt_q <= '0;
		else if (rx_clear)
			cnt_q <= '0; // Block handed to the cipher
		else if (wr_ok)
			cnt_q <= cnt_q + 1'b1;
	end

	// Shift in at the low end so the oldest word ends up on top
	always_ff @(posedge tb_clk)
	begin
		if (wr_ok)
			block_q <= {block_q[`AES_BLOCK_W-`AES_WORD_W-1:0], rx_data};
	end

	// Controller only consumes a complete block
	assert property (@(posedge tb_clk) disable iff (!arst_n) rx_clear |-> rx_full)
		else $error("rx_clear raised with a partial block");

endmodule

// File: design/aes_key_expand.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// On-the-fly AES-128 key schedule, one round key per step
// round_key is always the key for the round the next step applies
// The input key must hold still between load and the last step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_key_expand (
	input  logic                tb_clk,
	input  logic                arst_n,
	input  aes_pkg::aes_block_t key,
	input  logic                load,
	input  logic                step,
	output aes_pkg::aes_block_t round_key
);

	aes_pkg::aes_block_t key_q; // Key of the round last applied
	logic [7:0] rcon_q; // Rcon for the next derivation
	aes_pkg::aes_word_t w0;
	aes_pkg::aes_word_t w1;
	aes_pkg::aes_word_t w2;
	aes_pkg::aes_word_t w3;
	aes_pkg::aes_word_t g_w; // g() applied to the last word
	aes_pkg::aes_word_t n0;
	aes_pkg::aes_word_t n1;
	aes_pkg::aes_word_t n2;
	aes_pkg::aes_word_t n3;

	// S-box on each byte of a word
	function automatic aes_pkg::aes_word_t sub_word(input aes_pkg::aes_word_t w);
		return {aes_pkg::sbox[w[31:24]], aes_pkg::sbox[w[23:16]],
			aes_pkg::sbox[w[15:8]], aes_pkg::sbox[w[7:0]]};
	endfunction

	assign {w0, w1, w2, w3} = key_q;

	// RotWord then SubWord then Rcon in the top byte
	assign g_w = sub_word({w3[23:0], w3[31:24]}) ^ {rcon_q, {(`AES_WORD_W-8){1'b0}}};

	assign n0 = w0 ^ g_w;
	assign n1 = w1 ^ n0; // Each word chains off the one before
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;
	assign round_key = {n0, n1, n2, n3};

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
			rcon_q <= 8'h01;
		else if (load)
			rcon_q <= 8'h01; // Round 1 constant
		else if (step)
			rcon_q <= aes_pkg::gf_double(rcon_q); // 01 02 04 ... 1b 36
	end

	always_ff @(posedge tb_clk)
	begin
		if (load)
			key_q <= key; // Round 0 key is the cipher key
		else if (step)
			key_q <= round_key;
	end

	// Controller never loads a block while rounds are running
	assert property (@(posedge tb_clk) disable iff (!arst_n) !(load && step))
		else $error("load and step together");

endmodule

// File: design/aes_round.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Iterative AES cipher state, one full round per step
// Load does the initial AddRoundKey with the raw key
// Column-major byte order as in FIPS-197, byte n = row + 4*col
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_round (
	input  logic                tb_clk,
	input  logic                arst_n,
	input  aes_pkg::aes_block_t block_in,
	input  aes_pkg::aes_block_t key,
	input  aes_pkg::aes_block_t round_key,
	input  logic                load,
	input  logic                step,
	input  logic                last_round,
	output aes_pkg::aes_block_t state
);

	localparam int msb = `AES_BLOCK_W - 1;

	aes_pkg::aes_block_t state_q;
	aes_pkg::aes_block_t ss_d; // After SubBytes and ShiftRows
	aes_pkg::aes_block_t mc_d; // After MixColumns
	aes_pkg::aes_block_t next_d;

	// SubBytes and ShiftRows together with row r rotated left by r
	function automatic aes_pkg::aes_block_t sub_shift(input aes_pkg::aes_block_t s);
		aes_pkg::aes_block_t o;
		int r;
		int c;
		int src;
		o = '0;
		for (c = 0; c < `AES_WORDS_PER_BLOCK; c++)
		begin
			for (r = 0; r < 4; r++)
			begin
				src = r + 4 * ((c + r) % 4); // Byte that moves into (r, c)
				o[msb-8*(r+4*c) -: 8] = aes_pkg::sbox[s[msb-8*src -: 8]];
			end
		end
		return o;
	endfunction

	// Each column times the fixed 02 03 01 01 circulant
	function automatic aes_pkg::aes_block_t mix_columns(input aes_pkg::aes_block_t s);
		aes_pkg::aes_block_t o;
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		int c;
		o = '0;
		for (c = 0; c < `AES_WORDS_PER_BLOCK; c++)
		begin
			{a0, a1, a2, a3} = s[msb-`AES_WORD_W*c -: `AES_WORD_W];
			o[msb-`AES_WORD_W*c -: 8] = aes_pkg::gf_double(a0 ^ a1) ^ a1 ^ a2 ^ a3;
			o[msb-`AES_WORD_W*c-8 -: 8] = aes_pkg::gf_double(a1 ^ a2) ^ a2 ^ a3 ^ a0;
			o[msb-`AES_WORD_W*c-16 -: 8] = aes_pkg::gf_double(a2 ^ a3) ^ a3 ^ a0 ^ a1;
			o[msb-`AES_WORD_W*c-24 -: 8] = aes_pkg::gf_double(a3 ^ a0) ^ a0 ^ a1 ^ a2;
		end
		return o;
	endfunction

	assign ss_d = sub_shift(state_q);
	assign mc_d = mix_columns(ss_d);
	assign next_d = (last_round ? ss_d : mc_d) ^ round_key; // Round 10 skips MixColumns
	assign state = state_q;

	// Cipher state register
	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
			state_q <= '0;
		else if (load)
			state_q <= block_in ^ key; // Initial AddRoundKey
		else if (step)
			state_q <= next_d;
	end

endmodule

// File: design/aes_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequencer for one AES-128 encryption, 11 cycles from start to done
// start is only taken when idle with a full rx block and an empty tx side
// A refused start is dropped and must be pulsed again
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_ctrl (
	input  logic tb_clk,
	input  logic arst_n,
	input  logic start,
	input  logic rx_full,
	input  logic tx_empty,
	output logic rx_clear,
	output logic load,
	output logic step,
	output logic last_round,
	output logic tx_load,
	output logic busy,
	output logic done
);

	typedef enum logic [1:0] {
		st_idle, // Waiting for an accepted start
		st_run, // Ten rounds at one per cycle
		st_handoff // Ciphertext goes to the tx side
	} ctrl_state_t;

	localparam aes_pkg::aes_round_cnt_t final_round = aes_pkg::aes_round_cnt_t'(`AES_ROUNDS);

	ctrl_state_t fsm_q;
	aes_pkg::aes_round_cnt_t round_q; // Round that the next step applies
	logic done_q;
	logic accept;

	assign accept = (fsm_q == st_idle) && start && rx_full && tx_empty;

	assign load = accept; // Same cycle as start and lands on edge 0
	assign rx_clear = accept; // Frees rx for the next block
	assign step = (fsm_q == st_run);
	assign last_round = step && (round_q == final_round);
	assign tx_load = (fsm_q == st_handoff);
	assign busy = (fsm_q != st_idle);
	assign done = done_q;

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fsm_q <= st_idle;
			round_q <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= tx_load; // Pulse follows the tx capture edge
			case (fsm_q)
				st_idle:
				begin
					if (accept)
					begin
						fsm_q <= st_run;
						round_q <= aes_pkg::aes_round_cnt_t'(1);
					end
				end
				st_run:
				begin
					round_q <= round_q + 1'b1;
					if (last_round)
						fsm_q <= st_handoff; // Edge 10 applied the final round
				end
				st_handoff:
					fsm_q <= st_idle; // busy drops on the capture edge
				default:
					fsm_q <= st_idle;
			endcase
		end
	end

	// Rounds only run inside an encryption and stay within 1 to 10
	assert property (@(posedge tb_clk) disable iff (!arst_n)
		step |-> (busy && round_q != '0 && round_q <= final_round))
		else $error("step outside busy or with a round count out of range");

	// One done per block
	assert property (@(posedge tb_clk) disable iff (!arst_n) done |=> !done)
		else $error("done held for two cycles");

endmodule

// File: design/tx_word_unpacker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transmit side, hands out one ciphertext block as four words
// tx_data always shows the top word, most significant first
// tx_data is undefined until the first block is loaded
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "aes_macros.svh"

module tx_word_unpacker (
	input  logic                tb_clk,
	input  logic                arst_n,
	input  aes_pkg::aes_block_t state,
	input  logic                tx_load,
	input  logic                tx_read,
	output aes_pkg::aes_word_t  tx_data,
	output logic                tx_empty
);

	localparam int cnt_w = $clog2(`AES_WORDS_PER_BLOCK) + 1;
	localparam logic [cnt_w-1:0] cnt_full = cnt_w'(`AES_WORDS_PER_BLOCK);

	logic [cnt_w-1:0] cnt_q; // Words still to be read
	aes_pkg::aes_block_t block_q;
	logic rd_ok;

	assign tx_empty = (cnt_q == '0);
	assign rd_ok = tx_read && !tx_empty; // Reads on empty do nothing
	assign tx_data = block_q[`AES_BLOCK_W-1 -: `AES_WORD_W];

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
			cnt_q <= '0;
		else if (tx_load)
			cnt_q <= cnt_full; // Fresh block, all four words pending
		else if (rd_ok)
			cnt_q <= cnt_q - 1'b1;
	end

	// Shift out at the top, zeros fill from below
	always_ff @(posedge tb_clk)
	begin
		if (tx_load)
			block_q <= state;
		else if (rd_ok)
			block_q <= {block_q[`AES_BLOCK_W-`AES_WORD_W-1:0], {`AES_WORD_W{1'b0}}};
	end

endmodule

// File: design/aes_core_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 encryption core with word-wide rx and tx ports
// Encrypt only; key is a level held from start until done
// Wait for rx_full and tx_empty before pulsing start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module aes_core_top (
	input  logic                tb_clk,
	input  logic                arst_n,
	input  logic                rx_write,
	input  aes_pkg::aes_word_t  rx_data,
	input  aes_pkg::aes_block_t key,
	input  logic                start,
	input  logic                tx_read,
	output logic                rx_full,
	output logic                busy,
	output logic                done,
	output aes_pkg::aes_word_t  tx_data,
	output logic                tx_empty
);

	aes_pkg::aes_block_t block_in; // Packed plaintext
	aes_pkg::aes_block_t round_key; // Key for the next round
	aes_pkg::aes_block_t state; // Cipher state, ciphertext after round 10
	logic rx_clear;
	logic load;
	logic step;
	logic last_round;
	logic tx_load;

	rx_word_packer u_packer (
		.tb_clk   (tb_clk),
		.arst_n   (arst_n),
		.rx_write (rx_write),
		.rx_data  (rx_data),
		.rx_clear (rx_clear),
		.block_in (block_in),
		.rx_full  (rx_full)
	);

	aes_key_expand u_key_expand (
		.tb_clk    (tb_clk),
		.arst_n    (arst_n),
		.key       (key),
		.load      (load),
		.step      (step),
		.round_key (round_key)
	);

	aes_round u_round (
		.tb_clk     (tb_clk),
		.arst_n     (arst_n),
		.block_in   (block_in),
		.key        (key),
		.round_key  (round_key),
		.load       (load),
		.step       (step),
		.last_round (last_round),
		.state      (state)
	);

	aes_ctrl u_ctrl (
		.tb_clk     (tb_clk),
		.arst_n     (arst_n),
		.start      (start),
		.rx_full    (rx_full),
		.tx_empty   (tx_empty),
		.rx_clear   (rx_clear),
		.load       (load),
		.step       (step),
		.last_round (last_round),
		.tx_load    (tx_load),
		.busy       (busy),
		.done       (done)
	);

	tx_word_unpacker u_unpacker (
		.tb_clk   (tb_clk),
		.arst_n   (arst_n),
		.state    (state),
		.tx_load  (tx_load),
		.tx_read  (tx_read),
		.tx_data  (tx_data),
		.tx_empty (tx_empty)
	);

endmodule

// File: sim/tb_aes_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the AES-128 encryption core
// Inputs change and outputs are sampled on the falling edge
// Vectors are FIPS-197 Appendix B and C.1, all-zero and SP 800-38A ECB
// Every wait loop gives up after wait_limit cycles and ends the run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "aes_macros.svh"

module tb_aes_core;

	localparam int n_vec = 6;
	localparam int wait_limit = 100; // Cycles before any wait gives up
	localparam int idle_cycles = 20; // Window for a refused start

	// Index 0 is Appendix B, 1 is Appendix C.1, 2 all zero, 3 to 5 ECB
	localparam aes_pkg::aes_block_t vec_key [n_vec] = '{
		128'h2b7e1516_28aed2a6_abf71588_09cf4f3c,
		128'h00010203_04050607_08090a0b_0c0d0e0f,
		128'h00000000_00000000_00000000_00000000,
		128'h2b7e1516_28aed2a6_abf71588_09cf4f3c,
		128'h2b7e1516_28aed2a6_abf71588_09cf4f3c,
		128'h2b7e1516_28aed2a6_abf71588_09cf4f3c
	};
	localparam aes_pkg::aes_block_t vec_pt [n_vec] = '{
		128'h3243f6a8_885a308d_313198a2_e0370734,
		128'h00112233_44556677_8899aabb_ccddeeff,
		128'h00000000_00000000_00000000_00000000,
		128'h6bc1bee2_2e409f96_e93d7e11_7393172a,
		128'hae2d8a57_1e03ac9c_9eb76fac_45af8e51,
		128'h30c81c46_a35ce411_e5fbc119_1a0a52ef
	};
	localparam aes_pkg::aes_block_t vec_ct [n_vec] = '{
		128'h3925841d_02dc09fb_dc118597_196a0b32,
		128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a,
		128'h66e94bd4_ef8a2c3b_884cfa59_ca342b2e,
		128'h3ad77bb4_0d7a3660_a89ecaf3_2466ef97,
		128'hf5d3d585_03b9699d_e785895a_96fdbaaf,
		128'h43b1cd7f_598ece23_881b00e3_ed030688
	};

	logic tb_clk;
	logic arst_n;
	logic rx_write;
	aes_pkg::aes_word_t rx_data;
	aes_pkg::aes_block_t key;
	logic start;
	logic tx_read;
	logic rx_full;
	logic busy;
	logic done;
	aes_pkg::aes_word_t tx_data;
	logic tx_empty;

	logic [31:0] lfsr_q; // Filler word source
	string test_name;
	int test_errs; // Errors in the running test
	int err_total;
	int tests_run;
	int tests_failed;
	int n_cycles;
	int i;
	aes_pkg::aes_word_t filler;

	aes_core_top UUT (
		.tb_clk   (tb_clk),
		.arst_n   (arst_n),
		.rx_write (rx_write),
		.rx_data  (rx_data),
		.key      (key),
		.start    (start),
		.tx_read  (tx_read),
		.rx_full  (rx_full),
		.busy     (busy),
		.done     (done),
		.tx_data  (tx_data),
		.tx_empty (tx_empty)
	);

	initial
	begin
		tb_clk = 1'b0;
		forever #2 tb_clk = ~tb_clk; // 4 ns period
	end

	// done comes after busy drops and with ciphertext waiting
	assert property (@(posedge tb_clk) disable iff (!arst_n) done |-> (!busy && !tx_empty))
	else
	begin
		$display("done raised while still busy or with no ciphertext to read");
		test_errs++;
	end

	// Only a start pulse can wake the core
	assert property (@(posedge tb_clk) disable iff (!arst_n) $rose(busy) |-> $past(start))
	else
	begin
		$display("busy rose without a start pulse");
		test_errs++;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_word(output aes_pkg::aes_word_t w);
		int b;
		w = '0;
		for (b = 0; b < `AES_WORD_W; b++)
		begin
			lfsr_q = lfsr_next(lfsr_q); // One step per bit taken
			w = {w[`AES_WORD_W-2:0], lfsr_q[0]};
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic check_val(input aes_pkg::aes_block_t exp, input aes_pkg::aes_block_t act);
		assert (act === exp)
		else
		begin
			$display("error %s: expected %0h actual %0h", test_name, exp, act);
			test_errs++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		err_total += test_errs;
		if (test_errs == 0)
			$display("test %s: ok", test_name);
		else
		begin
			$display("test %s: failed with %0d errors", test_name, test_errs);
			tests_failed++;
		end
	endtask

	// Words go out first-is-top at one per falling edge
	task automatic write_block(input aes_pkg::aes_block_t blk);
		int w;
		for (w = 0; w < `AES_WORDS_PER_BLOCK; w++)
		begin
			rx_write = 1'b1;
			rx_data = blk[`AES_BLOCK_W-1-`AES_WORD_W*w -: `AES_WORD_W];
			@(negedge tb_clk);
		end
		rx_write = 1'b0;
	endtask

	task automatic wait_rx_full();
		int n;
		n = 0;
		while (!rx_full)
		begin
			@(negedge tb_clk);
			n++;
			if (n > wait_limit)
				abort_run("timed out waiting for rx_full");
		end
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(negedge tb_clk); // Edge 0 samples it
		start = 1'b0;
	endtask

	// Counts edges since the start edge until done shows
	task automatic wait_done(output int cycles);
		cycles = 0;
		while (!done)
		begin
			@(negedge tb_clk);
			cycles++;
			if (cycles > wait_limit)
				abort_run("timed out waiting for done");
		end
	endtask

	task automatic read_block(input aes_pkg::aes_block_t exp);
		int w;
		for (w = 0; w < `AES_WORDS_PER_BLOCK; w++)
		begin
			check_val(exp[`AES_BLOCK_W-1-`AES_WORD_W*w -: `AES_WORD_W], tx_data);
			tx_read = 1'b1;
			@(negedge tb_clk);
		end
		tx_read = 1'b0;
		check_val(1, tx_empty); // Drained after the fourth read
	endtask

	task automatic hold_idle();
		int n;
		for (n = 0; n < idle_cycles; n++)
		begin
			check_val(0, busy);
			check_val(0, done);
			@(negedge tb_clk);
		end
	endtask

	task automatic check_reset_state();
		check_val(0, rx_full);
		check_val(1, tx_empty);
		check_val(0, busy);
		check_val(0, done);
	endtask

	initial
	begin
		#100000;
		abort_run("simulation ran past its time limit");
	end

	initial
	begin
		arst_n = 1'b0;
		rx_write = 1'b0;
		rx_data = '0;
		key = '0;
		start = 1'b0;
		tx_read = 1'b0;
		lfsr_q = 32'hd5fa_5611;
		err_total = 0;
		tests_run = 0;
		tests_failed = 0;
		test_errs = 0;
		repeat (3) @(negedge tb_clk); // Three rising edges in reset
		arst_n = 1'b1;

		begin_test("reset_state");
		check_reset_state();
		end_test();

		// Extra word while full must be dropped
		begin_test("pack_overflow");
		key = vec_key[1];
		write_block(vec_pt[1]);
		wait_rx_full();
		next_word(filler);
		rx_write = 1'b1;
		rx_data = filler;
		@(negedge tb_clk);
		rx_write = 1'b0;
		check_val(1, rx_full);
		pulse_start();
		wait_done(n_cycles);
		read_block(vec_ct[1]);
		end_test();

		for (i = 0; i < n_vec; i++)
		begin
			begin_test($sformatf("vector_%0d", i));
			key = vec_key[i];
			write_block(vec_pt[i]);
			wait_rx_full();
			pulse_start();
			wait_done(n_cycles);
			check_val(11, n_cycles); // Start edge to done
			read_block(vec_ct[i]);
			end_test();
		end

		begin_test("start_reject");
		pulse_start(); // rx empty
		hold_idle();
		key = vec_key[0];
		write_block(vec_pt[0]);
		wait_rx_full();
		pulse_start();
		wait_done(n_cycles);
		write_block(vec_pt[3]); // tx still holds the last result
		wait_rx_full();
		pulse_start();
		hold_idle();
		read_block(vec_ct[0]);
		key = vec_key[3];
		pulse_start(); // Held block goes now
		wait_done(n_cycles);
		read_block(vec_ct[3]);
		end_test();

		begin_test("back_to_back");
		key = vec_key[4];
		write_block(vec_pt[4]);
		wait_rx_full();
		pulse_start();
		write_block(vec_pt[5]); // Overlaps the rounds
		check_val(1, busy);
		wait_done(n_cycles);
		read_block(vec_ct[4]);
		wait_rx_full();
		key = vec_key[5];
		pulse_start();
		wait_done(n_cycles);
		read_block(vec_ct[5]);
		end_test();

		begin_test("reset_mid_run");
		key = vec_key[1];
		write_block(vec_pt[1]);
		wait_rx_full();
		pulse_start();
		write_block(vec_pt[2]); // Next block fills rx during the rounds
		check_val(1, rx_full);
		check_val(1, busy);
		arst_n = 1'b0;
		@(negedge tb_clk);
		arst_n = 1'b1;
		check_reset_state();
		end_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
		if (tests_failed == 0 && err_total == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+design
design/aes_pkg.sv
design/rx_word_packer.sv
design/aes_key_expand.sv
design/aes_round.sv
design/aes_ctrl.sv
design/tx_word_unpacker.sv
design/aes_core_top.sv
sim/tb_aes_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the AES core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_aes_core \
	-f vlog.f \
	-o sim_tb_aes_core

./obj_dir/sim_tb_aes_core | tee sim.log

if grep -q "TESTS PASSED" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
